// File: hw/wb_host_pkg.sv
// Wishbone host shared bus types, register map and reset values
package wb_host_pkg;

   // --------------------------------------
   // Bus and field types
   // --------------------------------------
   // Full Wishbone address
   typedef logic [31:0] wb_addr_t;
   // Wishbone data word
   typedef logic [31:0] wb_data_t;
   // Byte enables
   typedef logic [3:0]  wb_sel_t;
   // Upper address byte for slave accesses
   typedef logic [7:0]  bank_sel_t;
   // Register index, from address bits 3:2
   typedef logic [1:0]  reg_idx_t;

   // --------------------------------------
   // Register map
   // --------------------------------------
   // Global control, reset and clock fields
   localparam reg_idx_t REG_GLB_CTRL  = 2'd0;
   // Bank select and boot remap
   localparam reg_idx_t REG_BANK      = 2'd1;
   // Free clock control words
   localparam reg_idx_t REG_CLK_CTRL1 = 2'd2;
   localparam reg_idx_t REG_CLK_CTRL2 = 2'd3;

   // Address bit that picks the local register space
   localparam int LOCAL_SEL_BIT = 23;

   // --------------------------------------
   // Reset values
   // --------------------------------------
   // All block resets asserted, both clocks in pass-through
   localparam wb_data_t   GLB_CTRL_RST   = '0;
   localparam bank_sel_t  BANK_SEL_RST   = 8'h10;
   localparam logic [3:0] BOOT_REMAP_RST = 4'h0;
   localparam wb_data_t   CLK_CTRL_RST   = '0;

   // Clock divider ratio widths
   localparam int CPU_RATIO_W = 2;
   localparam int USB_RATIO_W = 3;

   // Number of block reset outputs in register 0
   localparam int RST_CNT = 7;

endpackage

// File: hw/clk_div.sv
// Programmable even clock divider with reference pass-through
`timescale 1ns/100ps

module clk_div #(
   parameter int RATIO_W = 2
) (
   input  logic               ref_clk_i,
   input  logic               wbm_rst_n,
   input  logic               div_en_i,
   input  logic [RATIO_W-1:0] ratio_i,
   output logic               clk_o
);

   logic [RATIO_W-1:0] cnt;
   logic               clk_div;

   // Toggle every ratio+1 reference edges
   // Held idle while the divider is bypassed
   always_ff @(posedge ref_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         cnt     <= '0;
         clk_div <= 1'b0;
      end
      else if (!div_en_i)
      begin
         cnt     <= '0;
         clk_div <= 1'b0;
      end
      else if (cnt >= ratio_i)
      begin
         cnt     <= '0;
         clk_div <= ~clk_div;
      end
      else
      begin
         cnt <= cnt + 1'b1;
      end
   end

   // Bypass mux, reference clock when divide is off
   assign clk_o = div_en_i ? clk_div : ref_clk_i;

   // Counter stays in range once the ratio has settled
   a_cnt_range : assert property (@(posedge ref_clk_i) disable iff (!wbm_rst_n || !div_en_i)
      $stable(ratio_i) |-> cnt <= ratio_i);

endmodule

// File: hw/wb_host_router.sv
// Wishbone host router, local register or bank-extended slave access
`timescale 1ns/100ps

module wb_host_router (
   input  logic                   wbm_clk_i,
   input  logic                   wbm_rst_n,
   input  logic                   wbm_cyc_i,
   input  logic                   wbm_stb_i,
   input  wb_host_pkg::wb_addr_t  wbm_adr_i,
   input  wb_host_pkg::bank_sel_t bank_sel_i,
   input  wb_host_pkg::wb_data_t  wbs_dat_i,
   input  logic                   wbs_ack_i,
   input  logic                   wbs_err_i,
   input  wb_host_pkg::wb_data_t  reg_rdata_i,
   input  logic                   reg_ack_i,
   output wb_host_pkg::wb_data_t  wbm_dat_o,
   output logic                   wbm_ack_o,
   output logic                   wbm_err_o,
   output logic                   wbs_cyc_o,
   output logic                   wbs_stb_o,
   output wb_host_pkg::wb_addr_t  wbs_adr_o,
   output logic                   reg_req_o
);
   import wb_host_pkg::*;

   logic wb_req;
   logic local_acc;

   // Registered strobe, makes the bus a multi-cycle path
   // Cleared once the access ends with ack or error
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wb_req <= 1'b0;
      end
      else
      begin
         wb_req <= wbm_stb_i && !wbm_ack_o && !wbm_err_o;
      end
   end

   // Address bit 23 picks the local register space
   assign local_acc = wbm_adr_i[LOCAL_SEL_BIT];
   assign reg_req_o = wb_req && local_acc;

   // Remote side
   assign wbs_cyc_o = wbm_cyc_i;
   assign wbs_stb_o = wb_req && !local_acc;
   // Bank select replaces the top address byte
   assign wbs_adr_o = {bank_sel_i, wbm_adr_i[23:0]};

   // --------------------------------------
   // Response mux
   // --------------------------------------
   assign wbm_dat_o = reg_req_o ? reg_rdata_i : wbs_dat_i;
   assign wbm_ack_o = reg_req_o ? reg_ack_i : (wbs_stb_o && wbs_ack_i);
   // Local registers never answer with an error
   assign wbm_err_o = wbs_stb_o && wbs_err_i;

   // Responses only come back on the path that holds the request
   a_one_path : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !(reg_ack_i && !reg_req_o) && !((wbs_ack_i || wbs_err_i) && !wbs_stb_o));

endmodule

// File: hw/wb_host_regs.sv
// Wishbone host configuration registers with registered read data and ack
`timescale 1ns/100ps

module wb_host_regs (
   input  logic                   wbm_clk_i,
   input  logic                   wbm_rst_n,
   input  logic                   reg_req_i,
   input  logic                   we_i,
   input  wb_host_pkg::reg_idx_t  idx_i,
   input  wb_host_pkg::wb_data_t  wdata_i,
   output wb_host_pkg::wb_data_t  rdata_o,
   output logic                   ack_o,
   output wb_host_pkg::wb_data_t  glb_ctrl_o,
   output wb_host_pkg::bank_sel_t bank_sel_o,
   output logic [3:0]             boot_remap_o,
   output wb_host_pkg::wb_data_t  clk_ctrl1_o,
   output wb_host_pkg::wb_data_t  clk_ctrl2_o
);
   import wb_host_pkg::*;

   logic     acc_en;
   logic     wr_en;
   wb_data_t rd_mux;

   // New access only when the previous ack is gone
   assign acc_en = reg_req_i && !ack_o;
   assign wr_en  = acc_en && we_i;

   // --------------------------------------
   // Register bank
   // --------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_ctrl_o   <= GLB_CTRL_RST;
         bank_sel_o   <= BANK_SEL_RST;
         boot_remap_o <= BOOT_REMAP_RST;
         clk_ctrl1_o  <= CLK_CTRL_RST;
         clk_ctrl2_o  <= CLK_CTRL_RST;
      end
      else if (wr_en)
      begin
         case (idx_i)
            REG_GLB_CTRL:
            begin
               glb_ctrl_o <= wdata_i;
            end
            REG_BANK:
            begin
               // Bank in 7:0, boot remap in 11:8
               bank_sel_o   <= wdata_i[7:0];
               boot_remap_o <= wdata_i[11:8];
            end
            REG_CLK_CTRL1:
            begin
               clk_ctrl1_o <= wdata_i;
            end
            default:
            begin
               clk_ctrl2_o <= wdata_i;
            end
         endcase
      end
   end

   // Read mux, upper bits of register 1 read as zero
   always_comb
   begin
      case (idx_i)
         REG_GLB_CTRL:  rd_mux = glb_ctrl_o;
         REG_BANK:      rd_mux = {20'h0, boot_remap_o, bank_sel_o};
         REG_CLK_CTRL1: rd_mux = clk_ctrl1_o;
         default:       rd_mux = clk_ctrl2_o;
      endcase
   end

   // --------------------------------------
   // Response
   // --------------------------------------
   // One-cycle ack after each request
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         ack_o <= 1'b0;
      end
      else
      begin
         ack_o <= acc_en;
      end
   end

   // Read data captured with the ack
   always_ff @(posedge wbm_clk_i)
   begin
      if (acc_en)
      begin
         rdata_o <= rd_mux;
      end
   end

   // Request released after its ack, so no second ack follows
   a_ack_single : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      ack_o |=> !reg_req_i);

endmodule

// File: hw/wb_host.sv
// Wishbone host top with local config registers, slave forwarding and clock dividers
`timescale 1ns/100ps

module wb_host (
   input  logic                  wbm_clk_i,
   input  logic                  wbm_rst_n,
   input  logic                  user_clock1_i,
   input  logic                  user_clock2_i,

   // Master port
   input  logic                  wbm_cyc_i,
   input  logic                  wbm_stb_i,
   input  wb_host_pkg::wb_addr_t wbm_adr_i,
   input  logic                  wbm_we_i,
   input  wb_host_pkg::wb_data_t wbm_dat_i,
   input  wb_host_pkg::wb_sel_t  wbm_sel_i,
   output wb_host_pkg::wb_data_t wbm_dat_o,
   output logic                  wbm_ack_o,
   output logic                  wbm_err_o,

   // Slave port, same clock as master
   output logic                  wbs_cyc_o,
   output logic                  wbs_stb_o,
   output wb_host_pkg::wb_addr_t wbs_adr_o,
   output logic                  wbs_we_o,
   output wb_host_pkg::wb_data_t wbs_dat_o,
   output wb_host_pkg::wb_sel_t  wbs_sel_o,
   input  wb_host_pkg::wb_data_t wbs_dat_i,
   input  logic                  wbs_ack_i,
   input  logic                  wbs_err_i,

   // Block resets, active low
   output logic                  wbd_int_rst_n_o,
   output logic                  cpu_rst_n_o,
   output logic                  spi_rst_n_o,
   output logic                  sdram_rst_n_o,
   output logic                  uart_rst_n_o,
   output logic                  i2cm_rst_n_o,
   output logic                  mbist_rst_n_o,

   output logic [1:0]            uart_i2c_usb_sel_o,
   output logic [3:0]            cfg_boot_remap_o,
   output wb_host_pkg::wb_data_t cfg_clk_ctrl1_o,
   output wb_host_pkg::wb_data_t cfg_clk_ctrl2_o,
   output logic                  cpu_clk_o,
   output logic                  usb_clk_o
);
   import wb_host_pkg::*;

   logic               reg_req;
   logic               reg_ack;
   wb_data_t           reg_rdata;
   wb_data_t           glb_ctrl;
   bank_sel_t          bank_sel;
   logic [RST_CNT-1:0] blk_rst_n;

   // --------------------------------------
   // Request routing
   // --------------------------------------
   wb_host_router u_router (
      .wbm_clk_i   (wbm_clk_i),
      .wbm_rst_n   (wbm_rst_n),
      .wbm_cyc_i   (wbm_cyc_i),
      .wbm_stb_i   (wbm_stb_i),
      .wbm_adr_i   (wbm_adr_i),
      .bank_sel_i  (bank_sel),
      .wbs_dat_i   (wbs_dat_i),
      .wbs_ack_i   (wbs_ack_i),
      .wbs_err_i   (wbs_err_i),
      .reg_rdata_i (reg_rdata),
      .reg_ack_i   (reg_ack),
      .wbm_dat_o   (wbm_dat_o),
      .wbm_ack_o   (wbm_ack_o),
      .wbm_err_o   (wbm_err_o),
      .wbs_cyc_o   (wbs_cyc_o),
      .wbs_stb_o   (wbs_stb_o),
      .wbs_adr_o   (wbs_adr_o),
      .reg_req_o   (reg_req)
   );

   // Write side goes straight to the slave
   assign wbs_we_o  = wbm_we_i;
   assign wbs_dat_o = wbm_dat_i;
   assign wbs_sel_o = wbm_sel_i;

   // --------------------------------------
   // Local configuration registers
   // --------------------------------------
   wb_host_regs u_regs (
      .wbm_clk_i    (wbm_clk_i),
      .wbm_rst_n    (wbm_rst_n),
      .reg_req_i    (reg_req),
      .we_i         (wbm_we_i),
      .idx_i        (wbm_adr_i[3:2]),
      .wdata_i      (wbm_dat_i),
      .rdata_o      (reg_rdata),
      .ack_o        (reg_ack),
      .glb_ctrl_o   (glb_ctrl),
      .bank_sel_o   (bank_sel),
      .boot_remap_o (cfg_boot_remap_o),
      .clk_ctrl1_o  (cfg_clk_ctrl1_o),
      .clk_ctrl2_o  (cfg_clk_ctrl2_o)
   );

   // Block resets straight from register 0, no inversion
   assign blk_rst_n       = glb_ctrl[RST_CNT-1:0];
   assign wbd_int_rst_n_o = blk_rst_n[0];
   assign cpu_rst_n_o     = blk_rst_n[1];
   assign spi_rst_n_o     = blk_rst_n[2];
   assign sdram_rst_n_o   = blk_rst_n[3];
   assign uart_rst_n_o    = blk_rst_n[4];
   assign i2cm_rst_n_o    = blk_rst_n[5];
   assign mbist_rst_n_o   = blk_rst_n[6];

   assign uart_i2c_usb_sel_o = glb_ctrl[8:7];

   // --------------------------------------
   // Clock generators
   // --------------------------------------
   // CPU clock from user_clock1, divide bit 22, ratio 21:20
   clk_div #(.RATIO_W(CPU_RATIO_W)) u_cpu_clk (
      .ref_clk_i (user_clock1_i),
      .wbm_rst_n (wbm_rst_n),
      .div_en_i  (glb_ctrl[22]),
      .ratio_i   (glb_ctrl[21:20]),
      .clk_o     (cpu_clk_o)
   );

   // USB clock from user_clock2, divide bit 31, ratio 30:28
   clk_div #(.RATIO_W(USB_RATIO_W)) u_usb_clk (
      .ref_clk_i (user_clock2_i),
      .wbm_rst_n (wbm_rst_n),
      .div_en_i  (glb_ctrl[31]),
      .ratio_i   (glb_ctrl[30:28]),
      .clk_o     (usb_clk_o)
   );

endmodule

// File: verification/wb_slave_model.sv
// Behavioral Wishbone slave memory with one-cycle ack and error on a marked bank
`timescale 1ns/100ps

module wb_slave_model #(
   parameter logic [7:0] ERR_BANK = 8'hEE
) (
   input  logic                  wbm_clk_i,
   input  logic                  wbm_rst_n,
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  wb_host_pkg::wb_addr_t adr_i,
   input  logic                  we_i,
   input  wb_host_pkg::wb_data_t dat_i,
   input  wb_host_pkg::wb_sel_t  sel_i,
   output wb_host_pkg::wb_data_t dat_o,
   output logic                  ack_o,
   output logic                  err_o
);
   import wb_host_pkg::*;

   wb_data_t   mem [0:255];
   logic [7:0] idx;
   logic       take;

   // Word index from address bits 9:2
   assign idx  = adr_i[9:2];
   // New access only while no response is out
   assign take = cyc_i && stb_i && !ack_o && !err_o;

   // Fill pattern built from every index bit
   initial
   begin
      for (int i = 0; i < 256; i++)
      begin
         mem[i] = {i[7:0] ^ 8'h5A, i[7:0], ~i[7:0], i[7:0] ^ 8'hA5};
      end
      dat_o = '0;
   end

   // --------------------------------------
   // Response flops
   // --------------------------------------
   always @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
      end
      else
      begin
         // Marked bank answers with error instead of ack
         ack_o <= take && (adr_i[31:24] != ERR_BANK);
         err_o <= take && (adr_i[31:24] == ERR_BANK);
      end
   end

   // Memory access, byte lanes follow sel
   always @(posedge wbm_clk_i)
   begin
      if (take && (adr_i[31:24] != ERR_BANK))
      begin
         for (int b = 0; b < 4; b++)
         begin
            if (we_i && sel_i[b])
            begin
               mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
         dat_o <= mem[idx];
      end
   end

endmodule

// File: verification/tb_wb_host.sv
// Testbench for the Wishbone host, replays register, slave and clock cases from a file
`timescale 1ns/100ps

module tb_wb_host;
   import wb_host_pkg::*;

   localparam int        CLK_PERIOD  = 100;
   localparam int        RST_CYCLES  = 16;
   localparam int        ACK_LIMIT   = 20;
   localparam int        CASE_CYCLES = 40;
   localparam int        MAX_CASES   = 64;
   // Slave answers accesses in this bank with error
   localparam bank_sel_t ERR_BANK    = 8'hEE;

   logic       wbm_clk_i;
   logic       wbm_rst_n;
   logic       user_clock1_i;
   logic       user_clock2_i;
   logic       wbm_cyc_i;
   logic       wbm_stb_i;
   wb_addr_t   wbm_adr_i;
   logic       wbm_we_i;
   wb_data_t   wbm_dat_i;
   wb_sel_t    wbm_sel_i;
   wb_data_t   wbm_dat_o;
   logic       wbm_ack_o;
   logic       wbm_err_o;
   logic       wbs_cyc_o;
   logic       wbs_stb_o;
   wb_addr_t   wbs_adr_o;
   logic       wbs_we_o;
   wb_data_t   wbs_dat_o;
   wb_sel_t    wbs_sel_o;
   wb_data_t   wbs_dat_i;
   logic       wbs_ack_i;
   logic       wbs_err_i;
   logic       wbd_int_rst_n_o;
   logic       cpu_rst_n_o;
   logic       spi_rst_n_o;
   logic       sdram_rst_n_o;
   logic       uart_rst_n_o;
   logic       i2cm_rst_n_o;
   logic       mbist_rst_n_o;
   logic [1:0] uart_i2c_usb_sel_o;
   logic [3:0] cfg_boot_remap_o;
   wb_data_t   cfg_clk_ctrl1_o;
   wb_data_t   cfg_clk_ctrl2_o;
   logic       cpu_clk_o;
   logic       usb_clk_o;

   // Case table, loaded before reset ends
   logic [31:0] c_kind [0:MAX_CASES-1];
   wb_addr_t    c_adr  [0:MAX_CASES-1];
   wb_data_t    c_dat  [0:MAX_CASES-1];
   wb_sel_t     c_sel  [0:MAX_CASES-1];
   wb_data_t    c_exp  [0:MAX_CASES-1];
   int          n_cases = 0;
   logic        cases_loaded = 1'b0;

   int val_errs  = 0;
   int timeouts  = 0;
   int file_errs = 0;

   wb_host i_wb_host (.*);

   wb_slave_model #(.ERR_BANK(ERR_BANK)) u_slave (
      .wbm_clk_i (wbm_clk_i),
      .wbm_rst_n (wbm_rst_n),
      .cyc_i     (wbs_cyc_o),
      .stb_i     (wbs_stb_o),
      .adr_i     (wbs_adr_o),
      .we_i      (wbs_we_o),
      .dat_i     (wbs_dat_o),
      .sel_i     (wbs_sel_o),
      .dat_o     (wbs_dat_i),
      .ack_o     (wbs_ack_i),
      .err_o     (wbs_err_i)
   );

   // --------------------------------------
   // Clocks
   // --------------------------------------
   initial
   begin
      wbm_clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) wbm_clk_i = ~wbm_clk_i;
   end

   // 40 ns reference for the CPU divider
   initial
   begin
      user_clock1_i = 1'b0;
      forever #20 user_clock1_i = ~user_clock1_i;
   end

   // 60 ns reference for the USB divider
   initial
   begin
      user_clock2_i = 1'b0;
      forever #30 user_clock2_i = ~user_clock2_i;
   end

   // One classic Wishbone access, driven on falling edges
   task automatic wb_access(
      input  logic     we,
      input  wb_addr_t adr,
      input  wb_data_t dat,
      input  wb_sel_t  sel,
      output wb_data_t rdata,
      output logic     ack,
      output logic     err,
      output logic     slv_seen,
      output wb_addr_t slv_adr,
      output logic     timed_out
   );
      int cycles;
      begin
         ack       = 1'b0;
         err       = 1'b0;
         slv_seen  = 1'b0;
         slv_adr   = '0;
         rdata     = '0;
         timed_out = 1'b0;
         cycles    = 0;
         @(negedge wbm_clk_i);
         wbm_cyc_i = 1'b1;
         wbm_stb_i = 1'b1;
         wbm_adr_i = adr;
         wbm_we_i  = we;
         wbm_dat_i = dat;
         wbm_sel_i = sel;
         while (!ack && !err && !timed_out)
         begin
            @(negedge wbm_clk_i);
            cycles++;
            // Remember the forwarded address while the slave strobe is up
            if (wbs_stb_o)
            begin
               slv_seen = 1'b1;
               slv_adr  = wbs_adr_o;
            end
            ack   = wbm_ack_o;
            err   = wbm_err_o;
            rdata = wbm_dat_o;
            if (cycles >= ACK_LIMIT && !ack && !err)
            begin
               timed_out = 1'b1;
            end
         end
         if (timed_out)
         begin
            $display("Access to address %h got neither ack nor error within %0d cycles",
                     adr, ACK_LIMIT);
            timeouts++;
         end
         // Drop the strobe on the falling edge after the response
         wbm_cyc_i = 1'b0;
         wbm_stb_i = 1'b0;
         wbm_we_i  = 1'b0;
      end
   endtask

   // Reset outputs and peripheral select against register 0 bits 8:0
   task automatic check_resets(input logic [8:0] exp_bits);
      logic [6:0] rst_vec;
      begin
         rst_vec = {mbist_rst_n_o, i2cm_rst_n_o, uart_rst_n_o, sdram_rst_n_o,
                    spi_rst_n_o, cpu_rst_n_o, wbd_int_rst_n_o};
         assert (rst_vec === exp_bits[6:0] && uart_i2c_usb_sel_o === exp_bits[8:7])
         else
         begin
            $display("** Error at %0t: resets/sel expected %h/%h, got %h/%h",
                     $time, exp_bits[6:0], exp_bits[8:7], rst_vec, uart_i2c_usb_sel_o);
            val_errs++;
         end
      end
   endtask

   // Boot remap and clock control outputs against the tracked register values
   task automatic check_cfg(input logic [3:0] exp_remap, input wb_data_t exp_ctrl1,
                            input wb_data_t exp_ctrl2);
      begin
         assert (cfg_boot_remap_o === exp_remap && cfg_clk_ctrl1_o === exp_ctrl1 &&
                 cfg_clk_ctrl2_o === exp_ctrl2)
         else
         begin
            $display("** Error at %0t: remap/ctrl1/ctrl2 expected %h/%h/%h, got %h/%h/%h",
                     $time, exp_remap, exp_ctrl1, exp_ctrl2, cfg_boot_remap_o,
                     cfg_clk_ctrl1_o, cfg_clk_ctrl2_o);
            val_errs++;
         end
      end
   endtask

   // Period between two rising edges once the divider has settled
   task automatic measure_period(input logic [31:0] clk_id, output realtime period);
      realtime t0;
      begin
         t0 = 0.0;
         for (int i = 0; i < 4; i++)
         begin
            if (clk_id == 1)
               @(posedge cpu_clk_o);
            else
               @(posedge usb_clk_o);
            if (i == 2)
               t0 = $realtime;
         end
         period = $realtime - t0;
      end
   endtask

   // --------------------------------------
   // Main sequence
   // --------------------------------------
   initial
   begin
      int          fd;
      int          n;
      logic [31:0] tok;
      logic [8*128-1:0] skip_line;
      wb_data_t    rdata;
      logic        got_ack;
      logic        got_err;
      logic        slv_seen;
      wb_addr_t    slv_adr;
      logic        timed_out;
      logic        is_wr;
      logic        is_local;
      logic        exp_err;
      bank_sel_t   exp_bank;
      logic [3:0]  exp_remap;
      wb_data_t    exp_ctrl1;
      wb_data_t    exp_ctrl2;
      realtime     per;

      wbm_rst_n = 1'b0;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_adr_i = '0;
      wbm_we_i  = 1'b0;
      wbm_dat_i = '0;
      wbm_sel_i = '0;
      exp_bank  = BANK_SEL_RST;
      exp_remap = 4'h0;
      exp_ctrl1 = '0;
      exp_ctrl2 = '0;

      fd = $fopen("verification/wb_host_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the cases file verification/wb_host_cases.txt");
         file_errs++;
      end
      else
      begin
         // A lone # token starts a comment line
         while ($fscanf(fd, "%s", tok) == 1)
         begin
            if (tok == "#")
            begin
               n = $fgets(skip_line, fd);
            end
            else if (n_cases < MAX_CASES)
            begin
               n = $fscanf(fd, "%h %h %h %h", c_adr[n_cases], c_dat[n_cases],
                           c_sel[n_cases], c_exp[n_cases]);
               if (n != 4)
               begin
                  $display("Case line %0d of the cases file is malformed", n_cases);
                  file_errs++;
               end
               c_kind[n_cases] = tok;
               n_cases++;
            end
         end
         $fclose(fd);
      end
      cases_loaded = 1'b1;

      repeat (RST_CYCLES) @(posedge wbm_clk_i);
      @(negedge wbm_clk_i);
      wbm_rst_n = 1'b1;

      // Everything held in reset, CPU clock in pass-through
      @(negedge wbm_clk_i);
      check_resets(9'h000);
      check_cfg(exp_remap, exp_ctrl1, exp_ctrl2);
      for (int s = 0; s < 4; s++)
      begin
         #7;
         assert (cpu_clk_o === user_clock1_i)
         else
         begin
            $display("** Error at %0t: cpu_clk_o does not follow user_clock1_i", $time);
            val_errs++;
         end
      end

      for (int k = 0; k < n_cases; k++)
      begin
         if (c_kind[k] == "ck")
         begin
            measure_period(c_adr[k], per);
            assert (per > c_exp[k] - 0.5 && per < c_exp[k] + 0.5)
            else
            begin
               $display("** Error at %0t: clock %0d period expected %0d ns, got %0.1f ns",
                        $time, c_adr[k], c_exp[k], per);
               val_errs++;
            end
         end
         else
         begin
            is_wr    = (c_kind[k] == "wr") || (c_kind[k] == "wre");
            exp_err  = (c_kind[k] == "rde") || (c_kind[k] == "wre");
            is_local = c_adr[k][LOCAL_SEL_BIT];
            wb_access(is_wr, c_adr[k], c_dat[k], c_sel[k], rdata, got_ack, got_err,
                      slv_seen, slv_adr, timed_out);
            if (!timed_out)
            begin
               // Local accesses ack and never error, slave side as the case says
               assert (got_ack == !exp_err && got_err == exp_err && !(is_local && got_err))
               else
               begin
                  $display("** Error at %0t: case %0d expected ack %0b err %0b, got %0b %0b",
                           $time, k, !exp_err, exp_err, got_ack, got_err);
                  val_errs++;
               end
               if (!is_local)
               begin
                  assert (slv_seen && slv_adr === {exp_bank, c_adr[k][23:0]})
                  else
                  begin
                     $display("** Error at %0t: slave address expected %h, got %h",
                              $time, {exp_bank, c_adr[k][23:0]}, slv_adr);
                     val_errs++;
                  end
               end
               if (!is_wr && !exp_err)
               begin
                  assert (rdata === c_exp[k])
                  else
                  begin
                     $display("** Error at %0t: read of %h expected %h, got %h",
                              $time, c_adr[k], c_exp[k], rdata);
                     val_errs++;
                  end
               end
               // Track what the local writes should have changed
               if (is_local && is_wr && c_adr[k][3:2] == REG_GLB_CTRL)
                  check_resets(c_dat[k][8:0]);
               if (is_local && is_wr && c_adr[k][3:2] == REG_BANK)
               begin
                  exp_bank  = c_dat[k][7:0];
                  exp_remap = c_dat[k][11:8];
               end
               if (is_local && is_wr && c_adr[k][3:2] == REG_CLK_CTRL1)
                  exp_ctrl1 = c_dat[k];
               if (is_local && is_wr && c_adr[k][3:2] == REG_CLK_CTRL2)
                  exp_ctrl2 = c_dat[k];
               if (is_local && is_wr)
                  check_cfg(exp_remap, exp_ctrl1, exp_ctrl2);
            end
         end
      end

      $display("Run finished: %0d value errors, %0d timeouts, %0d file errors",
               val_errs, timeouts, file_errs);
      if (val_errs == 0 && timeouts == 0 && file_errs == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // Watchdog sized from the case count plus reset
   initial
   begin
      wait (cases_loaded);
      #((n_cases * CASE_CYCLES + RST_CYCLES + 8) * CLK_PERIOD);
      $display("Watchdog expired, the run did not complete within %0d cycles",
               n_cases * CASE_CYCLES + RST_CYCLES + 8);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// File: build.f
hw/wb_host_pkg.sv
hw/clk_div.sv
hw/wb_host_router.sv
hw/wb_host_regs.sv
hw/wb_host.sv
verification/wb_slave_model.sv
verification/tb_wb_host.sv

// File: verification/wb_host_cases.txt
# kind addr data sel expect, all hex; kinds wr rd, wre rde expect error
# ck checks a clock, addr 1 cpu 2 usb, expect is the period in ns
rd 00800000 00000000 f 00000000
rd 00800004 00000000 f 00000010
rd 00800008 00000000 f 00000000
rd 0080000c 00000000 f 00000000
ck 00000001 00000000 0 00000028
ck 00000002 00000000 0 0000003c
wr 00800000 000001ff f 00000000
rd 00800000 00000000 f 000001ff
wr 00800000 00000155 f 00000000
rd 00800000 00000000 f 00000155
wr 00800004 ffffffff f 00000000
rd 00800004 00000000 f 00000fff
wr 00800008 12345678 f 00000000
rd 00800008 00000000 f 12345678
wr 0080000c a5a50ff0 f 00000000
rd 0080000c 00000000 f a5a50ff0
wr 00800004 0000035a f 00000000
wr 00000040 cafef00d f 00000000
rd 00000040 00000000 f cafef00d
wr 00800004 000000ee f 00000000
rde 00000040 00000000 f 00000000
wre 00000040 11111111 f 00000000
wr 00800004 00000010 f 00000000
rd 00800004 00000000 f 00000010
wr 00800000 b07001ff f 00000000
ck 00000001 00000000 0 00000140
ck 00000002 00000000 0 000001e0
wr 00800000 000001ff f 00000000
ck 00000001 00000000 0 00000028
ck 00000002 00000000 0 0000003c
